/* cornet_bus.sv */
`include "cornet_macros.svh"

module cornet_bus (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              rd_byte_req,
   input  logic              rd_word_req,
   input  cornet_pkg::addr_t rd_addr,
   input  logic              wr_req,
   input  cornet_pkg::addr_t wr_addr,
   input  cornet_pkg::data_t wr_req_data,
   input  cornet_pkg::addr_t fetch_addr,
   input  logic              fetch_rd_req,
   input  logic              fetch_hold,
   input  logic              ready,
   input  cornet_pkg::data_t rd_data,
   output cornet_pkg::addr_t addr,
   output logic              rd_req,
   output logic              wr_en,
   output cornet_pkg::data_t wr_data,
   output logic              rd_ack,
   output cornet_pkg::data_t rd_byte,
   output cornet_pkg::addr_t rd_word
);
   import cornet_pkg::*;

   typedef enum logic [1:0] {
      bus_idle,
      bus_byte,
      bus_word_lo,
      bus_word_hi
   } bus_state_t;

   bus_state_t state;
   addr_t      bus_addr;
   logic       bus_rd_req;

   assign rd_req = fetch_rd_req | bus_rd_req;
   assign addr   = fetch_hold ? fetch_addr : bus_addr;

   always_ff @(posedge clk)
   begin
      rd_ack     <= 1'b0;
      wr_en      <= 1'b0;
      bus_rd_req <= 1'b0;
      if (!reset_n)
      begin
         state <= bus_idle;
      end
      else if (rd_byte_req || rd_word_req)
      begin
         bus_addr   <= rd_addr;
         bus_rd_req <= 1'b1;
         state      <= rd_byte_req ? bus_byte : bus_word_lo;
      end
      else if (wr_req)
      begin
         bus_addr <= wr_addr;
         wr_data  <= wr_req_data;
         wr_en    <= 1'b1;
         state    <= bus_idle;
      end
      else if (ready && !bus_rd_req)  // data valid once ready returns.
      begin
         case (state)
            bus_byte:
            begin
               rd_byte <= rd_data;
               rd_ack  <= 1'b1;
               state   <= bus_idle;
            end
            bus_word_lo:
            begin
               rd_word[`CORNET_DATA_W-1:0] <= rd_data;
               bus_addr   <= bus_addr + addr_t'(1);  // high byte is little endian next.
               bus_rd_req <= 1'b1;
               state      <= bus_word_hi;
            end
            bus_word_hi:
            begin
               rd_word[`CORNET_ADDR_W-1:`CORNET_DATA_W] <= rd_data;
               rd_ack <= 1'b1;
               state  <= bus_idle;
            end
            default:
               state <= bus_idle;
         endcase
      end
   end

endmodule

/* cornet_cpu.sv */
module cornet_cpu (
   input  logic              clk,
   input  logic              reset_n,
   output cornet_pkg::addr_t addr,
   input  cornet_pkg::data_t rd_data,
   output cornet_pkg::data_t wr_data,
   output logic              wr_en,
   output logic              rd_req,
   input  logic              ready
);
   import cornet_pkg::*;

   addr_t       pc;
   addr_t       pc_next;
   opcode_t     opcode;
   logic        start_reset;
   logic        exec_start;
   logic        exec_wait;
   addr_t       fetch_addr;
   logic        fetch_rd_req;
   logic        fetch_hold;
   inst_state_t inst_state;
   inst_state_t next_op;
   logic [1:0]  pc_delta;
   logic        rd_byte_req;
   logic        rd_word_req;
   addr_t       rd_addr;
   logic        wr_req;
   addr_t       wr_addr;
   data_t       wr_req_data;
   logic        rd_ack;
   data_t       rd_byte;
   addr_t       rd_word;
   logic        inst_done;
   addr_t       op_addr;
   data_t       reg_a;
   logic        flag_z;

   cornet_fetch fetch_i (
      .clk, .reset_n, .ready, .rd_data, .inst_done, .pc_next, .pc, .opcode,
      .start_reset, .exec_start, .exec_wait, .fetch_addr, .fetch_rd_req, .fetch_hold
   );

   cornet_decode decode_i (
      .clk, .reset_n, .start_reset, .exec_start, .opcode, .pc, .flag_z, .next_op,
      .op_addr, .reg_a, .inst_state, .pc_delta, .rd_byte_req, .rd_word_req, .rd_addr,
      .wr_req, .wr_addr, .wr_req_data
   );

   cornet_execute execute_i (
      .clk, .reset_n, .exec_wait, .inst_state, .pc, .pc_delta, .rd_ack, .rd_byte,
      .rd_word, .inst_done, .pc_next, .next_op, .op_addr, .reg_a, .flag_z
   );

   cornet_bus bus_i (
      .clk, .reset_n, .rd_byte_req, .rd_word_req, .rd_addr, .wr_req, .wr_addr,
      .wr_req_data, .fetch_addr, .fetch_rd_req, .fetch_hold, .ready, .rd_data,
      .addr, .rd_req, .wr_en, .wr_data, .rd_ack, .rd_byte, .rd_word
   );

endmodule

/* cornet_decode.sv */
`include "cornet_macros.svh"

module cornet_decode (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    start_reset,
   input  logic                    exec_start,
   input  cornet_pkg::opcode_t     opcode,
   input  cornet_pkg::addr_t       pc,
   input  logic                    flag_z,
   input  cornet_pkg::inst_state_t next_op,
   input  cornet_pkg::addr_t       op_addr,
   input  cornet_pkg::data_t       reg_a,
   output cornet_pkg::inst_state_t inst_state,
   output logic [1:0]              pc_delta,
   output logic                    rd_byte_req,
   output logic                    rd_word_req,
   output cornet_pkg::addr_t       rd_addr,
   output logic                    wr_req,
   output cornet_pkg::addr_t       wr_addr,
   output cornet_pkg::data_t       wr_req_data
);
   import cornet_pkg::*;

   logic take_branch;

   // beq branches on z set, bne on z clear.
   assign take_branch = (opcode == op_beq) ? flag_z : !flag_z;

   always_ff @(posedge clk)
   begin
      rd_byte_req <= 1'b0;
      rd_word_req <= 1'b0;
      wr_req      <= 1'b0;
      if (!reset_n)
      begin
         inst_state <= inst_nop;
         pc_delta   <= '0;
      end
      else if (start_reset)
      begin
         rd_word_req <= 1'b1;
         rd_addr     <= `CORNET_RESET_VECTOR;
         inst_state  <= inst_reset;
      end
      else if (exec_start)
      begin
         rd_addr <= pc + addr_t'(1);  // operand follows the opcode.
         case (opcode)
            op_ora_imm:   inst_state <= inst_ora_imm;
            op_and_imm:   inst_state <= inst_and_imm;
            op_jmp_abs:   inst_state <= inst_jmp;
            op_sta_zp:    inst_state <= inst_sta_z;
            op_sta_abs:   inst_state <= inst_sta_abs;
            op_sta_abs_x: inst_state <= inst_sta_abs_x;
            op_lda_imm:   inst_state <= inst_lda;
            op_lda_zp:    inst_state <= inst_lda_z;
            op_lda_abs:   inst_state <= inst_lda_abs;
            op_lda_abs_x: inst_state <= inst_lda_abs_x;
            op_ldx_imm:   inst_state <= inst_ldx;
            op_ldy_imm:   inst_state <= inst_ldy;
            op_cmp_imm:   inst_state <= inst_cmp;
            op_cpx_imm:   inst_state <= inst_cpx;
            op_cpy_imm:   inst_state <= inst_cpy;
            op_inx:       inst_state <= inst_inx;
            op_iny:       inst_state <= inst_iny;
            op_dex:       inst_state <= inst_dex;
            op_dey:       inst_state <= inst_dey;
            op_bne,
            op_beq:       inst_state <= take_branch ? inst_branch : inst_no_branch;
            default:      inst_state <= inst_nop;  // unknown opcodes stall here.
         endcase

         case (opcode)
            op_ora_imm, op_and_imm, op_sta_zp, op_lda_imm, op_lda_zp,
            op_ldx_imm, op_ldy_imm, op_cmp_imm, op_cpx_imm, op_cpy_imm:
            begin
               rd_byte_req <= 1'b1;
               pc_delta    <= `CORNET_STEP_BYTE;
            end
            op_jmp_abs, op_sta_abs, op_sta_abs_x, op_lda_abs, op_lda_abs_x:
            begin
               rd_word_req <= 1'b1;
               pc_delta    <= `CORNET_STEP_WORD;
            end
            op_inx, op_iny, op_dex, op_dey:
               pc_delta <= `CORNET_STEP_IMPLIED;
            op_bne, op_beq:
            begin
               rd_byte_req <= take_branch;  // offset only needed when taken.
               pc_delta    <= take_branch ? 2'd0 : `CORNET_STEP_BYTE;
            end
            default:
               pc_delta <= '0;
         endcase
      end
      else
      begin
         case (next_op)
            inst_lda_addr:
            begin
               rd_byte_req <= 1'b1;
               rd_addr     <= op_addr;
               inst_state  <= inst_lda;
            end
            inst_sta_addr:
            begin
               wr_req      <= 1'b1;
               wr_addr     <= op_addr;
               wr_req_data <= reg_a;
               inst_state  <= inst_sta;
            end
            default:
               ;
         endcase
      end
   end

endmodule

/* cornet_execute.sv */
`include "cornet_macros.svh"

module cornet_execute (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    exec_wait,
   input  cornet_pkg::inst_state_t inst_state,
   input  cornet_pkg::addr_t       pc,
   input  logic [1:0]              pc_delta,
   input  logic                    rd_ack,
   input  cornet_pkg::data_t       rd_byte,
   input  cornet_pkg::addr_t       rd_word,
   output logic                    inst_done,
   output cornet_pkg::addr_t       pc_next,
   output cornet_pkg::inst_state_t next_op,
   output cornet_pkg::addr_t       op_addr,
   output cornet_pkg::data_t       reg_a,
   output logic                    flag_z
);
   import cornet_pkg::*;

   data_t reg_x;
   data_t reg_y;
   data_t and_val;
   data_t or_val;
   addr_t pc_step;
   addr_t branch_offset;
   addr_t branch_target;

   assign and_val       = reg_a & rd_byte;
   assign or_val        = reg_a | rd_byte;
   assign pc_step       = pc + addr_t'(pc_delta);
   assign branch_offset = {{(`CORNET_ADDR_W - `CORNET_DATA_W){rd_byte[`CORNET_DATA_W-1]}}, rd_byte};
   // offset is relative to the byte after the branch.
   assign branch_target = pc + addr_t'(`CORNET_STEP_BYTE) + branch_offset;

   always_ff @(posedge clk)
   begin
      inst_done <= 1'b0;
      next_op   <= inst_nop;
      if (!reset_n)
      begin
         flag_z <= 1'b0;
      end
      else if (exec_wait && !inst_done)
      begin
         case (inst_state)  // implied phases, no operand.
            inst_inx:
            begin
               reg_x  <= reg_x + 8'd1;
               flag_z <= (reg_x == 8'hff);
            end
            inst_iny:
            begin
               reg_y  <= reg_y + 8'd1;
               flag_z <= (reg_y == 8'hff);
            end
            inst_dex:
            begin
               reg_x  <= reg_x - 8'd1;
               flag_z <= (reg_x == 8'h01);
            end
            inst_dey:
            begin
               reg_y  <= reg_y - 8'd1;
               flag_z <= (reg_y == 8'h01);
            end
            default:
               ;
         endcase

         case (inst_state)
            inst_inx, inst_iny, inst_dex, inst_dey, inst_sta, inst_no_branch:
            begin
               pc_next   <= pc_step;
               inst_done <= 1'b1;
            end
            default:
               ;
         endcase

         if (rd_ack)
         begin
            case (inst_state)
               inst_reset:
               begin
                  reg_a     <= '0;
                  reg_x     <= '0;
                  pc_next   <= rd_word;
                  inst_done <= 1'b1;
               end
               inst_jmp:
               begin
                  pc_next   <= rd_word;
                  inst_done <= 1'b1;
               end
               inst_branch:
               begin
                  pc_next   <= branch_target;
                  inst_done <= 1'b1;
               end
               inst_lda:
               begin
                  reg_a  <= rd_byte;
                  flag_z <= (rd_byte == 8'h00);
               end
               inst_ldx:
               begin
                  reg_x  <= rd_byte;
                  flag_z <= (rd_byte == 8'h00);
               end
               inst_ldy:
               begin
                  reg_y  <= rd_byte;
                  flag_z <= (rd_byte == 8'h00);
               end
               inst_and_imm:
               begin
                  reg_a  <= and_val;
                  flag_z <= (and_val == 8'h00);
               end
               inst_ora_imm:
               begin
                  reg_a  <= or_val;
                  flag_z <= (or_val == 8'h00);
               end
               inst_cmp: flag_z <= (reg_a == rd_byte);
               inst_cpx: flag_z <= (reg_x == rd_byte);
               inst_cpy: flag_z <= (reg_y == rd_byte);
               inst_lda_z, inst_sta_z:
                  op_addr <= {`CORNET_ZERO_PAGE_HI, rd_byte};
               inst_lda_abs, inst_sta_abs:
                  op_addr <= rd_word;
               inst_lda_abs_x, inst_sta_abs_x:
                  op_addr <= rd_word + addr_t'(reg_x);
               default:
                  ;
            endcase

            case (inst_state)
               inst_lda, inst_ldx, inst_ldy, inst_and_imm, inst_ora_imm,
               inst_cmp, inst_cpx, inst_cpy:
               begin
                  pc_next   <= pc_step;
                  inst_done <= 1'b1;
               end
               inst_lda_z, inst_lda_abs, inst_lda_abs_x:
                  next_op <= inst_lda_addr;  // second phase reads the operand.
               inst_sta_z, inst_sta_abs, inst_sta_abs_x:
                  next_op <= inst_sta_addr;
               default:
                  ;
            endcase
         end
      end
   end

endmodule

/* cornet_fetch.sv */
module cornet_fetch (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                ready,
   input  cornet_pkg::data_t   rd_data,
   input  logic                inst_done,
   input  cornet_pkg::addr_t   pc_next,
   output cornet_pkg::addr_t   pc,
   output cornet_pkg::opcode_t opcode,
   output logic                start_reset,
   output logic                exec_start,
   output logic                exec_wait,
   output cornet_pkg::addr_t   fetch_addr,
   output logic                fetch_rd_req,
   output logic                fetch_hold
);
   import cornet_pkg::*;

   fetch_state_t state;

   assign start_reset = (state == fs_reset);
   assign exec_start  = (state == fs_execute);
   assign exec_wait   = (state == fs_execute_wait);

   always_ff @(posedge clk)
   begin
      fetch_rd_req <= 1'b0;
      fetch_hold   <= 1'b0;
      if (!reset_n)
      begin
         state <= fs_idle;
         pc    <= '0;
      end
      else
      begin
         case (state)
            fs_idle:
               state <= fs_reset;
            fs_reset:
               state <= fs_execute_wait;  // vector read is finished like an instruction.
            fs_fetch:
            begin
               fetch_addr   <= pc;
               fetch_rd_req <= 1'b1;
               fetch_hold   <= 1'b1;
               state        <= fs_load;
            end
            fs_load:
            begin
               fetch_hold <= 1'b1;  // keep the opcode address on the bus.
               if (ready && !fetch_rd_req)
               begin
                  opcode <= opcode_t'(rd_data);
                  state  <= fs_execute;
               end
            end
            fs_execute:
               state <= fs_execute_wait;
            fs_execute_wait:
               if (inst_done)
               begin
                  pc    <= pc_next;
                  state <= fs_fetch;
               end
            default:
               state <= fs_idle;
         endcase
      end
   end

endmodule

/* cornet_macros.svh */
`ifndef CORNET_MACROS_SVH
`define CORNET_MACROS_SVH

// bus widths.
`define CORNET_ADDR_W 16
`define CORNET_DATA_W 8

// low byte of the reset vector, high byte follows.
`define CORNET_RESET_VECTOR 16'hfffc

// high address byte for zero-page operands.
`define CORNET_ZERO_PAGE_HI 8'h00

// program counter steps per instruction length.
`define CORNET_STEP_IMPLIED 2'd1
`define CORNET_STEP_BYTE 2'd2
`define CORNET_STEP_WORD 2'd3

`endif

/* cornet_pkg.sv */
`include "cornet_macros.svh"

package cornet_pkg;

   typedef logic [`CORNET_ADDR_W-1:0] addr_t;
   typedef logic [`CORNET_DATA_W-1:0] data_t;

   typedef enum logic [7:0] {
      op_ora_imm   = 8'h09,
      op_and_imm   = 8'h29,
      op_jmp_abs   = 8'h4c,
      op_sta_zp    = 8'h85,
      op_dey       = 8'h88,
      op_sta_abs   = 8'h8d,
      op_sta_abs_x = 8'h9d,
      op_ldy_imm   = 8'ha0,
      op_ldx_imm   = 8'ha2,
      op_lda_zp    = 8'ha5,
      op_lda_imm   = 8'ha9,
      op_lda_abs   = 8'had,
      op_lda_abs_x = 8'hbd,
      op_cpy_imm   = 8'hc0,
      op_iny       = 8'hc8,
      op_cmp_imm   = 8'hc9,
      op_dex       = 8'hca,
      op_bne       = 8'hd0,
      op_cpx_imm   = 8'he0,
      op_inx       = 8'he8,
      op_beq       = 8'hf0
   } opcode_t;

   typedef enum logic [2:0] {
      fs_idle,
      fs_reset,
      fs_fetch,
      fs_load,
      fs_execute,
      fs_execute_wait
   } fetch_state_t;

   // one value per instruction phase.
   typedef enum logic [4:0] {
      inst_nop, inst_reset, inst_jmp, inst_branch, inst_no_branch,
      inst_lda, inst_ldx, inst_ldy,
      inst_lda_z, inst_lda_abs, inst_lda_abs_x, inst_lda_addr,
      inst_sta, inst_sta_z, inst_sta_abs, inst_sta_abs_x, inst_sta_addr,
      inst_inx, inst_iny, inst_dex, inst_dey,
      inst_cmp, inst_cpx, inst_cpy,
      inst_and_imm, inst_ora_imm
   } inst_state_t;

endpackage

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cornet \
   -f src.f -o tb_cornet > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_cornet > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* src.f */
+incdir+.
cornet_pkg.sv
cornet_fetch.sv
cornet_decode.sv
cornet_execute.sv
cornet_bus.sv
cornet_cpu.sv
tb_cornet_chk.sv
tb_cornet_monitor.sv
tb_cornet.sv

/* tb_cornet.sv */
module tb_cornet;
   timeunit 1ns;
   timeprecision 1ps;
   import cornet_pkg::*;

   localparam int N_ROWS        = 17;
   localparam int N_WRITES      = 17;
   localparam int WRITE_TIMEOUT = 20000;
   localparam int IDLE_CYCLES   = 200;

   // row is start address, byte count, then up to eight bytes from the left.
   localparam logic [83:0] PROG_ROWS [N_ROWS] = '{
      {16'hfffc, 4'd2, 64'h0004_0000_0000_0000},  // reset vector to 0400.
      {16'h0400, 4'd8, 64'ha911_8520_a205_a007},  // lda, sta zp, ldx, ldy.
      {16'h0408, 4'd8, 64'h8d00_03a9_229d_0003},
      {16'h0410, 4'd8, 64'he89d_0003_caca_9d00},  // inx, dex with abs,x stores.
      {16'h0418, 4'd8, 64'h03bd_0005_8d10_03a9},
      {16'h0420, 4'd8, 64'hf029_3c85_2109_0585},  // and, ora.
      {16'h0428, 4'd8, 64'h22a5_408d_1103_ad01},
      {16'h0430, 4'd8, 64'h0585_23c9_a7f0_0285},  // cmp and beq over markers.
      {16'h0438, 4'd8, 64'h30c9_00f0_0285_31e0},
      {16'h0440, 4'd8, 64'h04d0_0285_32c8_c008},
      {16'h0448, 4'd8, 64'hd002_8533_88c0_08d0},
      {16'h0450, 4'd8, 64'h0285_34a2_039d_4003},  // dex/bne countdown loop.
      {16'h0458, 4'd8, 64'hcad0_fa8d_5003_4c5e},
      {16'h0460, 4'd1, 64'h0400_0000_0000_0000},  // jmp to itself.
      {16'h0504, 4'd1, 64'h5a00_0000_0000_0000},
      {16'h0040, 4'd1, 64'hc300_0000_0000_0000},
      {16'h0501, 4'd1, 64'ha700_0000_0000_0000}
   };

   // write address and data, in order.
   logic [23:0] exp_rows [N_WRITES] = '{
      24'h0020_11, 24'h0300_11, 24'h0305_22, 24'h0306_22, 24'h0304_22,
      24'h0310_5a, 24'h0021_30, 24'h0022_35, 24'h0311_c3, 24'h0023_a7,
      24'h0031_a7, 24'h0032_a7, 24'h0033_a7, 24'h0343_a7, 24'h0342_a7,
      24'h0341_a7, 24'h0350_a7
   };

   logic        clk     = 1'b0;
   logic        reset_n = 1'b0;
   logic        ready   = 1'b1;
   data_t       rd_data = '0;
   addr_t       addr;
   data_t       wr_data;
   logic        wr_en;
   logic        rd_req;
   data_t       mem [0:65535];
   int          seed       = 32'h647bf85f;
   int          rand_val;
   logic [1:0]  stall_left = 2'd0;
   logic        read_busy  = 1'b0;
   addr_t       read_addr  = '0;
   int          timeouts   = 0;
   int          value_errors;
   int          other_errors;
   int          write_count;

   function automatic data_t fill_byte(input int i);
      return i[15:8] ^ i[7:0] ^ 8'h5c;  // mixes both address bytes.
   endfunction

   always #5 clk = ~clk;

   cornet_cpu dut_i (
      .clk, .reset_n, .addr, .rd_data, .wr_data, .wr_en, .rd_req, .ready
   );

   tb_cornet_monitor #(.N_WRITES(N_WRITES)) monitor_i (
      .clk, .reset_n, .addr, .rd_req, .wr_en, .wr_data, .exp_rows,
      .value_errors, .other_errors, .write_count
   );

   always @(posedge clk)
   begin
      if (!reset_n)
      begin
         ready     <= 1'b1;
         read_busy <= 1'b0;
      end
      else if (rd_req)
      begin
         ready     <= 1'b0;  // ready drops the cycle after the request.
         read_addr <= addr;
         rand_val = $random(seed);
         stall_left <= rand_val[1:0];
         read_busy  <= 1'b1;
      end
      else if (read_busy)
      begin
         if (stall_left == 2'd0)
         begin
            ready     <= 1'b1;
            rd_data   <= mem[read_addr];
            read_busy <= 1'b0;
         end
         else
            stall_left <= stall_left - 2'd1;
      end
      if (reset_n && wr_en)
         mem[addr] <= wr_data;
   end

   initial
   begin
      addr_t       a;
      logic [83:0] row;
      int          cycles;
      for (int i = 0; i < 65536; i++)
         mem[addr_t'(i)] <= fill_byte(i);
      for (int r = 0; r < N_ROWS; r++)
      begin
         row = PROG_ROWS[r];
         for (int j = 0; j < int'(row[67:64]); j++)
         begin
            a = row[83:68] + addr_t'(j);
            mem[a] <= row[63 - 8*j -: 8];
         end
      end
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;
      cycles = 0;
      while (write_count < N_WRITES && cycles < WRITE_TIMEOUT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (write_count < N_WRITES)
      begin
         $display("timeout while waiting for writes, saw %0d of %0d", write_count, N_WRITES);
         timeouts++;
      end
      else
         repeat (IDLE_CYCLES) @(posedge clk);  // no writes may follow the final jmp.
      $display("summary: %0d value errors, %0d other errors, %0d timeouts, %0d of %0d writes",
               value_errors, other_errors, timeouts, write_count, N_WRITES);
      if (value_errors + other_errors + timeouts == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* tb_cornet_chk.sv */
module tb_cornet_chk (
   input logic              clk,
   input logic              reset_n,
   input logic              rd_req,
   input logic              wr_en,
   input logic              ready,
   input cornet_pkg::addr_t addr
);
   timeunit 1ns;
   timeprecision 1ps;

   logic read_pending;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         read_pending <= 1'b0;
      else if (rd_req)
         read_pending <= 1'b1;
      else if (ready)
         read_pending <= 1'b0;  // data consumed.
   end

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req && wr_en))
      else $error("read request and write enable are high together");

   rd_req_pulse: assert property (@(posedge clk) disable iff (!reset_n)
      rd_req |=> !rd_req)
      else $error("read request is longer than one cycle");

   addr_held: assert property (@(posedge clk) disable iff (!reset_n)
      (read_pending && !rd_req) |-> $stable(addr))
      else $error("address changed while a read was pending");

endmodule

bind cornet_cpu tb_cornet_chk chk_i (
   .clk, .reset_n, .rd_req, .wr_en, .ready, .addr
);

/* tb_cornet_monitor.sv */
module tb_cornet_monitor #(
   parameter int N_WRITES = 17
) (
   input  logic              clk,
   input  logic              reset_n,
   input  cornet_pkg::addr_t addr,
   input  logic              rd_req,
   input  logic              wr_en,
   input  cornet_pkg::data_t wr_data,
   input  logic [23:0]       exp_rows [N_WRITES],
   output int                value_errors,
   output int                other_errors,
   output int                write_count
);
   timeunit 1ns;
   timeprecision 1ps;
   import cornet_pkg::*;

   int    value_cnt = 0;
   int    other_cnt = 0;
   int    write_cnt = 0;
   int    read_cnt  = 0;
   addr_t boot_reads [3] = '{16'hfffc, 16'hfffd, 16'h0400};  // vector, then its target.

   assign value_errors = value_cnt;
   assign other_errors = other_cnt;
   assign write_count  = write_cnt;

   task automatic compare_addr(input string what, input addr_t got, input addr_t expected);
      if (got !== expected)
      begin
         $display("CHECK FAILED %s: got %h expected %h", what, got, expected);
         value_cnt++;
      end
   endtask

   task automatic compare_data(input string what, input data_t got, input data_t expected);
      if (got !== expected)
      begin
         $display("CHECK FAILED %s: got %h expected %h", what, got, expected);
         value_cnt++;
      end
   endtask

   always @(negedge clk)  // outputs settle between edges.
   begin
      if (reset_n && rd_req && read_cnt < 3)
      begin
         compare_addr($sformatf("addr on read %0d", read_cnt), addr, boot_reads[read_cnt]);
         read_cnt++;
      end
      if (reset_n && wr_en)
      begin
         if (write_cnt < N_WRITES)
         begin
            compare_addr($sformatf("addr on write %0d", write_cnt), addr,
                         exp_rows[write_cnt][23:8]);
            compare_data($sformatf("wr_data on write %0d", write_cnt), wr_data,
                         exp_rows[write_cnt][7:0]);
         end
         else
         begin
            $display("unexpected extra write to %h with data %h", addr, wr_data);
            other_cnt++;
         end
         write_cnt++;
      end
   end

endmodule
